// File: all.f
rtl/exu_pkg.sv
rtl/exu_compare.sv
rtl/exu_divider.sv
rtl/exu_csr_bank.sv
rtl/exu_alu.sv
rtl/exu_top.sv
+incdir+sim
sim/tb_exu_top.sv

// File: build.sh
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed check fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f all.f --top-module tb_exu_top -Mdir obj_dir -o sim_exu
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_exu
run_status=$?
if [ $run_status -ne 0 ]; then
	echo "Simulation failed with status $run_status"
	exit $run_status
fi

exit 0

// File: sim/tb_model.svh
// Reference model, random source and result check for the execute unit testbench.
// Included inside the testbench module body after the package import.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Generator state, starts from the fixed seed
logic [63:0] lcg_state = 64'd26;

// Two LCG steps per word, keeping only the better upper halves
function automatic logic [63:0] next_rand();
	logic [63:0] first;
	lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
	first = lcg_state;
	lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
	return {first[63:32], lcg_state[63:32]};
endfunction

// Compares one result and stops the run at the first mismatch
task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
	if (exp !== act)
	begin
		$display("ERR %s expected %h actual %h", name, exp, act);
		$display("FAIL: see errors above");
		$fatal(1, "result mismatch in %s", name);
	end
endtask

// Every relation is written out on its own
function automatic logic [63:0] cmp_model(input logic [63:0] x, input logic [63:0] y);
	logic [63:0] f;
	f = '0;
	f[cmp_bit_eq] = (x == y);
	f[cmp_bit_ne] = (x != y);
	f[cmp_bit_lt] = ($signed(x) < $signed(y));
	f[cmp_bit_le] = ($signed(x) <= $signed(y));
	f[cmp_bit_gt] = ($signed(x) > $signed(y));
	f[cmp_bit_ge] = ($signed(x) >= $signed(y));
	f[cmp_bit_ltu] = (x < y);
	f[cmp_bit_leu] = (x <= y);
	f[cmp_bit_gtu] = (x > y);
	f[cmp_bit_geu] = (x >= y);
	return f;
endfunction

// The fill bit enters from the vacated side, rotates also bring back the bits shifted out
function automatic logic [63:0] shift_model(input logic [5:0] kind, input logic [63:0] x,
		input logic [5:0] n, input logic fl);
	logic [63:0] lo_fill;
	logic [63:0] hi_fill;
	logic [63:0] wrap_l;
	logic [63:0] wrap_r;
	lo_fill = fl ? ~({64{1'b1}} << n) : 64'd0;
	hi_fill = fl ? ~({64{1'b1}} >> n) : 64'd0;
	wrap_l = (n == 6'd0) ? 64'd0 : x >> (64 - int'(n));
	wrap_r = (n == 6'd0) ? 64'd0 : x << (64 - int'(n));
	case (kind)
	sh_asl:  return (x << n) | lo_fill;
	sh_lsr:  return (x >> n) | hi_fill;
	sh_rol:  return (x << n) | lo_fill | wrap_l;
	sh_ror:  return (x >> n) | hi_fill | wrap_r;
	sh_asr:  return $signed(x) >>> n;
	default: return bad_result;
	endcase
endfunction

// Result of a single-cycle instruction before the predicate is applied
function automatic logic [63:0] single_model(input logic [39:0] instr, input logic [63:0] x,
		input logic [63:0] y, input logic [63:0] z, input logic [63:0] csr_val);
	logic [5:0] fn;
	logic [5:0] n;
	fn = instr[fn_msb:fn_lsb];
	n = instr[shimm_bit] ? instr[shamt_msb:shamt_lsb] : y[5:0];
	case (instr[op_msb:op_lsb])
	op_r2:
		case (fn)
		fn_add:  return x + y;
		fn_sub:  return x - y;
		fn_cmp:  return cmp_model(x, y);
		fn_and:  return x & y;
		fn_or:   return x | y;
		fn_eor:  return x ^ y;
		fn_andc: return x & ~y;
		fn_nand: return ~(x & y);
		fn_nor:  return ~(x | y);
		fn_enor: return ~(x ^ y);
		fn_orc:  return x | ~y;
		fn_seq:  return {63'd0, x == y};
		fn_sne:  return {63'd0, x != y};
		fn_slt:  return {63'd0, $signed(x) < $signed(y)};
		fn_sle:  return {63'd0, $signed(x) <= $signed(y)};
		fn_sltu: return {63'd0, x < y};
		fn_sleu: return {63'd0, x <= y};
		default: return bad_result;
		endcase
	op_csr:   return csr_val;
	op_addi:  return x + y;
	op_cmpi:  return cmp_model(x, y);
	op_andi:  return x & y;
	op_ori:   return x | y;
	op_eori:  return x ^ y;
	op_slti:  return {63'd0, $signed(x) < $signed(y)};
	op_shift: return shift_model(fn, x, n, instr[fill_bit]);
	op_mov:   return x;
	op_ld, op_st: return x + y;
	op_ldx, op_stx: return x + (y << instr[scale_msb:scale_lsb]) + z;
	op_pfx:   return 64'd0;
	default:  return bad_result;
	endcase
endfunction

// Full 128-bit product, operands sign-extended for the signed kind
function automatic logic [127:0] mul_model(input logic sgn, input logic [63:0] x,
		input logic [63:0] y);
	logic [127:0] wx;
	logic [127:0] wy;
	wx = {{64{sgn & x[63]}}, x};
	wy = {{64{sgn & y[63]}}, y};
	return wx * wy;
endfunction

// Truncating divide, zero divisor gives all ones and keeps the dividend
task automatic div_model(input logic sgn, input logic [63:0] x, input logic [63:0] y,
		output logic [63:0] q, output logic [63:0] r);
	logic [63:0] mx;
	logic [63:0] my;
	mx = (sgn && x[63]) ? -x : x;
	my = (sgn && y[63]) ? -y : y;
	if (y == 64'd0)
	begin
		q = {64{1'b1}};
		r = x;
	end
	else
	begin
		q = (sgn && (x[63] ^ y[63])) ? -(mx / my) : mx / my;
		r = (sgn && x[63]) ? -(mx % my) : mx % my;
	end
endtask

`endif

// File: sim/tb_exu_top.sv
// Testbench for the integer execute unit.
// Random operations from an LCG are checked against the model in tb_model.svh.
// Multiplies and divides wait on their done levels, everything else is checked in the cycle.
`timescale 1ns/1ps

module tb_exu_top;
	import exu_pkg::*;

	localparam int clk_period = 4;
	localparam int n_single = 300;
	localparam int n_mul = 100;
	localparam int n_div = 60;
	localparam int n_csr_wr = 16;
	localparam int n_pred = 40;
	localparam int n_bad = 30;
	// Each operation gets 80 cycles, the longest ones being the divides
	localparam int total_ops = 2 * csr_count + n_single + 4 * n_mul + 2 * n_div
		+ n_csr_wr + n_pred + n_bad;

	logic            clk;
	logic            rst_n;
	logic            ld;
	logic            div_sgn;
	logic [ilen-1:0] ir;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] i;
	logic [xlen-1:0] t;
	logic [xlen-1:0] p;
	logic            csr_we;
	logic [2:0]      csr_wr_idx;
	logic [xlen-1:0] csr_wdata;
	logic [xlen-1:0] o;
	logic            mul_done;
	logic            div_done;
	logic            div_dbz;
	// Copy of the CSR contents as the testbench wrote them
	logic [xlen-1:0] csr_model [csr_count];

	// Single-cycle opcodes with r2 and shift weighted up
	opcode_e single_ops [16] = '{op_r2, op_r2, op_addi, op_cmpi, op_andi, op_ori, op_eori,
		op_slti, op_shift, op_shift, op_mov, op_ld, op_st, op_ldx, op_stx, op_pfx};
	func_e r2_fns [17] = '{fn_add, fn_sub, fn_cmp, fn_and, fn_or, fn_eor, fn_andc, fn_nand,
		fn_nor, fn_enor, fn_orc, fn_seq, fn_sne, fn_slt, fn_sle, fn_sltu, fn_sleu};

	`include "tb_model.svh"

	exu_top u_exu_top (
		.clk(clk), .rst_n(rst_n), .ld(ld), .div_sgn(div_sgn), .ir(ir), .a(a), .b(b),
		.i(i), .t(t), .p(p), .csr_we(csr_we), .csr_wr_idx(csr_wr_idx),
		.csr_wdata(csr_wdata), .o(o), .mul_done(mul_done), .div_done(div_done),
		.div_dbz(div_dbz)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ========================================================================
	// Watchdog
	// ========================================================================
	initial
	begin
		#(total_ops * 80 * clk_period);
		$display("Timeout: the run did not finish within %0d cycles", total_ops * 80);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

	// Packs the instruction fields, unused bits stay zero
	function automatic logic [ilen-1:0] make_ir(input logic [6:0] op, input logic [5:0] fn,
			input logic [5:0] sh, input logic shimm, input logic fl, input logic [1:0] sc,
			input logic [2:0] cs);
		logic [ilen-1:0] w;
		w = '0;
		w[op_msb:op_lsb] = op;
		w[fn_msb:fn_lsb] = fn;
		w[shamt_msb:shamt_lsb] = sh;
		w[shimm_bit] = shimm;
		w[fill_bit] = fl;
		w[scale_msb:scale_lsb] = sc;
		w[csr_msb:csr_lsb] = cs;
		return w;
	endfunction

	function automatic logic [ilen-1:0] random_ir();
		logic [63:0] r;
		opcode_e     op;
		logic [5:0]  fn;
		r = next_rand();
		op = single_ops[r[3:0]];
		fn = (op == op_shift) ? r[9:4] % 6'd5 : r2_fns[5'(r[9:4] % 6'd17)];
		return make_ir(op, fn, r[15:10], r[16], r[17], r[19:18], r[22:20]);
	endfunction

	// Second operand is sometimes equal to the first or small
	function automatic logic [63:0] pick_b(input logic [63:0] x);
		logic [63:0] r;
		r = next_rand();
		case (r[1:0])
		2'd0:    return x;
		2'd1:    return r >> r[7:2];
		default: return next_rand();
		endcase
	endfunction

	// Steps to the drive point 1 ns after the next rising edge
	task automatic to_drive_point();
		@(posedge clk);
		#1;
	endtask

	task automatic set_inputs(input logic [ilen-1:0] instr, input logic [63:0] x,
			input logic [63:0] y, input logic [63:0] z, input logic [63:0] tv,
			input logic [63:0] pv);
		ir = instr;
		a = x;
		b = y;
		i = z;
		t = tv;
		p = pv;
	endtask

	// Drives one combinational operation and checks o before the next edge
	task automatic single_op(input string name, input logic [ilen-1:0] instr,
			input logic [63:0] x, input logic [63:0] y, input logic [63:0] z,
			input logic [63:0] tv, input logic [63:0] pv, input logic [63:0] exp);
		to_drive_point();
		set_inputs(instr, x, y, z, tv, pv);
		@(negedge clk);
		check_value($sformatf("%s ir %h", name, instr), exp, o);
	endtask

	// Starts with ld, waits for mul_done, then reads the low and high halves
	task automatic mul_op(input logic sgn, input logic imm, input logic [63:0] x,
			input logic [63:0] y);
		logic [127:0]    prod;
		logic [ilen-1:0] lo_ir;
		prod = mul_model(sgn, x, y);
		if (imm)
			lo_ir = make_ir(sgn ? op_muli : op_mului, 6'd0, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		else
			lo_ir = make_ir(op_r2, sgn ? fn_mul : fn_mulu, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		to_drive_point();
		set_inputs(lo_ir, x, y, 64'd0, 64'd0, 64'd1);
		ld = 1'b1;
		to_drive_point();
		ld = 1'b0;
		while (mul_done !== 1'b1)
			@(negedge clk);
		check_value($sformatf("mul low sgn %0d a %h b %h", sgn, x, y), prod[63:0], o);
		to_drive_point();
		ir = make_ir(op_r2, sgn ? fn_mulh : fn_muluh, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		@(negedge clk);
		check_value($sformatf("mul high sgn %0d a %h b %h", sgn, x, y), prod[127:64], o);
	endtask

	// Starts with ld, waits for div_done, then reads quotient, remainder and dbz
	// The quotient is read through op_r2 or through the immediate opcodes
	task automatic div_op(input logic sgn, input logic imm, input logic [63:0] x,
			input logic [63:0] y);
		logic [63:0]     q;
		logic [63:0]     r;
		logic [ilen-1:0] quo_ir;
		div_model(sgn, x, y, q, r);
		if (imm)
			quo_ir = make_ir(sgn ? op_divi : op_divui, 6'd0, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		else
			quo_ir = make_ir(op_r2, sgn ? fn_div : fn_divu, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		to_drive_point();
		set_inputs(quo_ir, x, y, 64'd0, 64'd0, 64'd1);
		div_sgn = sgn;
		ld = 1'b1;
		to_drive_point();
		ld = 1'b0;
		while (div_done !== 1'b1)
			@(negedge clk);
		check_value($sformatf("div quo sgn %0d a %h b %h", sgn, x, y), q, o);
		check_value("div dbz", {63'd0, y == 64'd0}, {63'd0, div_dbz});
		to_drive_point();
		ir = make_ir(op_r2, sgn ? fn_mod : fn_modu, 6'd0, 1'b0, 1'b0, 2'd0, 3'd0);
		@(negedge clk);
		check_value($sformatf("div rem sgn %0d a %h b %h", sgn, x, y), r, o);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial
	begin
		logic [63:0]     r;
		logic [63:0]     x;
		logic [63:0]     y;
		logic [63:0]     pv;
		logic [ilen-1:0] instr;
		rst_n = 1'b0;
		ld = 1'b0;
		div_sgn = 1'b0;
		csr_we = 1'b0;
		csr_wr_idx = 3'd0;
		csr_wdata = '0;
		set_inputs('0, 64'd0, 64'd0, 64'd0, 64'd0, 64'd0);
		for (int k = 0; k < csr_count; k++)
			csr_model[k] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Flags and CSRs after reset
		@(negedge clk);
		check_value("reset mul_done", 64'd0, {63'd0, mul_done});
		check_value("reset div_done", 64'd0, {63'd0, div_done});
		check_value("reset div_dbz", 64'd0, {63'd0, div_dbz});
		for (int k = 0; k < csr_count; k++)
			single_op("reset csr", make_ir(op_csr, 6'd0, 6'd0, 1'b0, 1'b0, 2'd0, 3'(k)),
				next_rand(), next_rand(), 64'd0, 64'd0, 64'd1, 64'd0);

		// Random single-cycle operations with the predicate set
		for (int k = 0; k < n_single; k++)
		begin
			instr = random_ir();
			x = next_rand();
			y = pick_b(x);
			r = next_rand();
			pv = next_rand() | 64'd1;
			single_op("single", instr, x, y, r, next_rand(), pv,
				single_model(instr, x, y, r, 64'd0));
		end

		// Signed and unsigned multiplies, some through the immediate opcodes
		for (int k = 0; k < n_mul; k++)
		begin
			r = next_rand();
			mul_op(1'b1, r[0], next_rand(), pick_b(r));
			mul_op(1'b0, r[1], next_rand(), pick_b(r));
		end

		// Divides with zero divisors, minus one and the most-negative dividend mixed in
		for (int k = 0; k < n_div; k++)
		begin
			r = next_rand();
			x = (r[11:9] == 3'd0) ? {1'b1, 63'd0} : next_rand();
			case (r[2:0])
			3'd0:    y = 64'd0;
			3'd1:    y = {64{1'b1}};
			default: y = next_rand() >> r[8:3];
			endcase
			div_op(k[0] == 1'b0, r[12], x, y);
		end

		// Random CSR writes, then a read of every index
		for (int k = 0; k < n_csr_wr; k++)
		begin
			r = next_rand();
			to_drive_point();
			csr_we = 1'b1;
			csr_wr_idx = r[2:0];
			csr_wdata = next_rand();
			csr_model[r[2:0]] = csr_wdata;
		end
		to_drive_point();
		csr_we = 1'b0;
		// New data on the idle write port must not reach the bank
		r = next_rand();
		csr_wr_idx = r[2:0];
		csr_wdata = next_rand();
		for (int k = 0; k < csr_count; k++)
			single_op("csr read", make_ir(op_csr, 6'd0, 6'd0, 1'b0, 1'b0, 2'd0, 3'(k)),
				64'd0, 64'd0, 64'd0, 64'd0, 64'd1, csr_model[k]);

		// A clear predicate keeps the old target whatever the opcode
		for (int k = 0; k < n_pred; k++)
		begin
			r = next_rand();
			x = next_rand();
			single_op("predicate", r[ilen-1:0], next_rand(), next_rand(), next_rand(), x,
				next_rand() & ~64'd1, x);
		end

		// Undefined opcodes, r2 functions and shift kinds
		for (int k = 0; k < n_bad; k++)
		begin
			r = next_rand();
			case (k % 3)
			0: instr = make_ir(7'h14 + 7'(r[7:0] % 8'd107), 6'd0, 6'd0, 1'b0, 1'b0,
				2'd0, 3'd0);
			1: instr = make_ir(op_r2, 6'h19 + 6'(r[7:0] % 8'd39), 6'd0, 1'b0, 1'b0,
				2'd0, 3'd0);
			default: instr = make_ir(op_shift, 6'h05 + 6'(r[7:0] % 8'd59), r[13:8],
				r[14], r[15], 2'd0, 3'd0);
			endcase
			single_op("undefined", instr, next_rand(), next_rand(), 64'd0, 64'd0, 64'd1,
				bad_result);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: rtl/exu_top.sv
// Top level of the integer execute unit.
// Joins the datapath, the divider, the compare block and the CSR bank.
// The caller holds ir and the operands from ld until the matching done.
`timescale 1ns/1ps

module exu_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ld,
	input  logic                     div_sgn,
	input  logic [exu_pkg::ilen-1:0] ir,
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	input  logic [exu_pkg::xlen-1:0] i,
	input  logic [exu_pkg::xlen-1:0] t,
	input  logic [exu_pkg::xlen-1:0] p,
	input  logic                     csr_we,
	input  logic [2:0]               csr_wr_idx,
	input  logic [exu_pkg::xlen-1:0] csr_wdata,
	output logic [exu_pkg::xlen-1:0] o,
	output logic                     mul_done,
	output logic                     div_done,
	output logic                     div_dbz
);
	import exu_pkg::*;

	logic [xlen-1:0] cmp_flags;
	logic [xlen-1:0] div_quo;
	logic [xlen-1:0] div_rem;
	logic [xlen-1:0] csr_value;

	exu_compare u_compare (.a(a), .b(b), .flags(cmp_flags));

	exu_divider u_divider (
		.clk(clk), .rst_n(rst_n), .ld(ld), .sgn(div_sgn), .a(a), .b(b),
		.quo(div_quo), .rem(div_rem), .dbz(div_dbz), .done(div_done)
	);

	exu_csr_bank u_csr_bank (
		.clk(clk), .rst_n(rst_n), .ir(ir), .csr_we(csr_we),
		.csr_wr_idx(csr_wr_idx), .csr_wdata(csr_wdata), .csr_value(csr_value)
	);

	exu_alu u_alu (
		.clk(clk), .rst_n(rst_n), .ld(ld), .ir(ir), .a(a), .b(b), .i(i),
		.t(t), .p(p), .cmp_flags(cmp_flags), .div_quo(div_quo),
		.div_rem(div_rem), .csr_value(csr_value), .o(o), .mul_done(mul_done)
	);

endmodule

// File: rtl/exu_alu.sv
// Execute datapath of the integer unit.
// Holds the shifters and the multiply pipelines and selects the result by
// opcode and function. Divide, compare and CSR values come in from beside it.
// The predicate bit picks between that result and the old target value.
`timescale 1ns/1ps

module exu_alu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ld,
	input  logic [exu_pkg::ilen-1:0] ir,
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	input  logic [exu_pkg::xlen-1:0] i,
	input  logic [exu_pkg::xlen-1:0] t,
	input  logic [exu_pkg::xlen-1:0] p,
	input  logic [exu_pkg::xlen-1:0] cmp_flags,
	input  logic [exu_pkg::xlen-1:0] div_quo,
	input  logic [exu_pkg::xlen-1:0] div_rem,
	input  logic [exu_pkg::xlen-1:0] csr_value,
	output logic [exu_pkg::xlen-1:0] o,
	output logic                     mul_done
);
	import exu_pkg::*;

	opcode_e                       opcode;
	func_e                         func;
	shift_e                        shfn;
	logic [shamt_msb-shamt_lsb:0]  shamt;
	logic                          fill;
	logic [scale_msb-scale_lsb:0]  scale;
	logic [3*xlen-1:0]             shl;
	logic [3*xlen-1:0]             shr;
	logic [3*xlen-1:0]             asr;
	logic [2*xlen-1:0]             prod_s0;
	logic [2*xlen-1:0]             prod_s1;
	logic [2*xlen-1:0]             prod;
	logic [2*xlen-1:0]             produ_s0;
	logic [2*xlen-1:0]             produ_s1;
	logic [2*xlen-1:0]             produ;
	logic [3:0]                    mul_cnt;
	logic [xlen-1:0]               res;

	assign opcode = opcode_e'(ir[op_msb:op_lsb]);
	assign func = func_e'(ir[fn_msb:fn_lsb]);
	assign shfn = shift_e'(ir[fn_msb:fn_lsb]);
	assign scale = ir[scale_msb:scale_lsb];
	assign fill = ir[fill_bit];
	assign shamt = ir[shimm_bit] ? ir[shamt_msb:shamt_lsb] : b[shamt_msb-shamt_lsb:0];

	// ========================================================================
	// Shifters
	// ========================================================================
	// The operand sits in the middle third. Bits pushed out of it land in
	// the outer thirds, which is where the rotates pick them back up
	assign shl = {{xlen{1'b0}}, a, {xlen{fill}}} << shamt;
	assign shr = {{xlen{fill}}, a, {xlen{1'b0}}} >> shamt;
	assign asr = {{xlen{a[xlen-1]}}, a, {xlen{1'b0}}} >> shamt;

	// ========================================================================
	// Multipliers
	// ========================================================================
	// Three free-running stages, so the product shows up three edges later
	// Operands are widened to the full product width before the multiply
	always_ff @(posedge clk)
	begin
		prod_s0 <= $signed({{xlen{a[xlen-1]}}, a}) * $signed({{xlen{b[xlen-1]}}, b});
		prod_s1 <= prod_s0;
		prod <= prod_s1;
	end

	always_ff @(posedge clk)
	begin
		produ_s0 <= {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
		produ_s1 <= produ_s0;
		produ <= produ_s1;
	end

	// Ones fill the counter after ld and the flag follows its top bit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mul_cnt <= '0;
			mul_done <= 1'b0;
		end
		else if (ld)
		begin
			mul_cnt <= '0;
			mul_done <= 1'b0;
		end
		else
		begin
			mul_cnt <= {mul_cnt[2:0], 1'b1};
			mul_done <= mul_cnt[3];
		end
	end

	// ========================================================================
	// Result select
	// ========================================================================
	always_comb
	begin
		case (opcode)
		op_r2:
			case (func)
			fn_add:   res = a + b;
			fn_sub:   res = a - b;
			fn_cmp:   res = cmp_flags;
			fn_mul:   res = prod[xlen-1:0];
			fn_mulu:  res = produ[xlen-1:0];
			fn_mulh:  res = prod[2*xlen-1:xlen];
			fn_muluh: res = produ[2*xlen-1:xlen];
			// Signed or unsigned is chosen by div_sgn at the divider
			fn_div:   res = div_quo;
			fn_mod:   res = div_rem;
			fn_divu:  res = div_quo;
			fn_modu:  res = div_rem;
			fn_and:   res = a & b;
			fn_or:    res = a | b;
			fn_eor:   res = a ^ b;
			fn_andc:  res = a & ~b;
			fn_nand:  res = ~(a & b);
			fn_nor:   res = ~(a | b);
			fn_enor:  res = ~(a ^ b);
			fn_orc:   res = a | ~b;
			fn_seq:   res = xlen'(a == b);
			fn_sne:   res = xlen'(a != b);
			fn_slt:   res = xlen'($signed(a) < $signed(b));
			fn_sle:   res = xlen'($signed(a) <= $signed(b));
			fn_sltu:  res = xlen'(a < b);
			fn_sleu:  res = xlen'(a <= b);
			default:  res = bad_result;
			endcase
		op_csr:   res = csr_value;
		// Immediate forms find their constant already placed on b
		op_addi:  res = a + b;
		op_cmpi:  res = cmp_flags;
		op_muli:  res = prod[xlen-1:0];
		op_mului: res = produ[xlen-1:0];
		op_divi:  res = div_quo;
		op_divui: res = div_quo;
		op_andi:  res = a & b;
		op_ori:   res = a | b;
		op_eori:  res = a ^ b;
		op_slti:  res = xlen'($signed(a) < $signed(b));
		op_shift:
			case (shfn)
			sh_asl:   res = shl[2*xlen-1:xlen];
			sh_lsr:   res = shr[2*xlen-1:xlen];
			sh_rol:   res = shl[2*xlen-1:xlen] | shl[3*xlen-1:2*xlen];
			sh_ror:   res = shr[2*xlen-1:xlen] | shr[xlen-1:0];
			sh_asr:   res = asr[2*xlen-1:xlen];
			default:  res = bad_result;
			endcase
		op_mov:   res = a;
		// Address generation for plain and indexed accesses
		op_ld:    res = a + b;
		op_st:    res = a + b;
		op_ldx:   res = a + (b << scale) + i;
		op_stx:   res = a + (b << scale) + i;
		op_pfx:   res = '0;
		default:  res = bad_result;
		endcase
	end

	// A clear predicate leaves the target register's old value in place
	assign o = p[0] ? res : t;

endmodule

// File: rtl/exu_csr_bank.sv
// Bank of eight configuration and status registers.
// Written from the outside port, read by op_csr through the ir CSR field.
`timescale 1ns/1ps

module exu_csr_bank (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [exu_pkg::ilen-1:0] ir,
	input  logic                     csr_we,
	input  logic [2:0]               csr_wr_idx,
	input  logic [exu_pkg::xlen-1:0] csr_wdata,
	output logic [exu_pkg::xlen-1:0] csr_value
);
	import exu_pkg::*;

	logic [xlen-1:0] csr_q [csr_count];

	// Writes land on the edge where csr_we is high
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < csr_count; k++)
				csr_q[k] <= '0;
		end
		else if (csr_we)
		begin
			csr_q[csr_wr_idx] <= csr_wdata;
		end
	end

	// Read side is combinational so op_csr completes in one cycle
	assign csr_value = csr_q[ir[csr_msb:csr_lsb]];

endmodule

// File: rtl/exu_divider.sv
// Iterative restoring divider for the execute unit.
// A pulse on ld loads the operands, one quotient bit is produced per clock,
// and a final cycle fixes the signs and raises done with the dbz flag.
`timescale 1ns/1ps

module exu_divider (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ld,
	input  logic                     sgn,
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	output logic [exu_pkg::xlen-1:0] quo,
	output logic [exu_pkg::xlen-1:0] rem,
	output logic                     dbz,
	output logic                     done
);
	import exu_pkg::*;

	typedef enum logic [1:0] {idle, run, fix} div_state_e;

	div_state_e      state;
	logic [5:0]      cnt;
	// Dividend shifts out of the top while quotient bits shift in below
	logic [xlen-1:0] q_sh;
	logic [xlen-1:0] dvs;
	logic [xlen-1:0] part;
	logic [xlen:0]   shifted;
	logic [xlen:0]   trial;
	logic            neg_q;
	logic            neg_r;
	logic            zero;

	// One restoring step: bring in the next dividend bit and try a subtract
	always_comb
	begin
		shifted = {part, q_sh[xlen-1]};
		trial = shifted - {1'b0, dvs};
	end

	// ========================================================================
	// Sequencer
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= idle;
			cnt <= '0;
			done <= 1'b0;
			dbz <= 1'b0;
		end
		else if (ld)
		begin
			state <= run;
			cnt <= '0;
			done <= 1'b0;
			dbz <= 1'b0;
		end
		else
		begin
			case (state)
			run:
			begin
				cnt <= cnt + 6'd1;
				// Last of the xlen quotient bits goes in on this edge
				if (cnt == 6'(xlen - 1))
					state <= fix;
			end
			fix:
			begin
				state <= idle;
				done <= 1'b1;
				dbz <= zero;
			end
			default:
				state <= idle;
			endcase
		end
	end

	// ========================================================================
	// Datapath
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			// Signed operands are divided as magnitudes and fixed at the end
			q_sh <= (sgn && a[xlen-1]) ? -a : a;
			dvs <= (sgn && b[xlen-1]) ? -b : b;
			part <= '0;
			neg_q <= sgn & (a[xlen-1] ^ b[xlen-1]);
			neg_r <= sgn & a[xlen-1];
			zero <= (b == '0);
		end
		else if (state == run)
		begin
			// The partial remainder stays below the divisor, so it fits in xlen bits
			if (!trial[xlen])
			begin
				part <= trial[xlen-1:0];
				q_sh <= {q_sh[xlen-2:0], 1'b1};
			end
			else
			begin
				part <= shifted[xlen-1:0];
				q_sh <= {q_sh[xlen-2:0], 1'b0};
			end
		end
		else if (state == fix)
		begin
			// A zero divisor leaves |a| in part, so the remainder is the dividend
			quo <= zero ? '1 : (neg_q ? -q_sh : q_sh);
			rem <= neg_r ? -part : part;
		end
	end

endmodule

// File: rtl/exu_compare.sv
// Compare-flags generator for the execute unit.
// Produces every signed and unsigned relation of a and b as one word.
`timescale 1ns/1ps

module exu_compare (
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	output logic [exu_pkg::xlen-1:0] flags
);
	import exu_pkg::*;

	logic eq;
	logic lt;
	logic ltu;

	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	// The remaining relations all follow from equal, less and less-unsigned
	always_comb
	begin
		flags = '0;
		flags[cmp_bit_eq] = eq;
		flags[cmp_bit_ne] = ~eq;
		flags[cmp_bit_lt] = lt;
		flags[cmp_bit_le] = lt | eq;
		flags[cmp_bit_gt] = ~(lt | eq);
		flags[cmp_bit_ge] = ~lt;
		flags[cmp_bit_ltu] = ltu;
		flags[cmp_bit_leu] = ltu | eq;
		flags[cmp_bit_gtu] = ~(ltu | eq);
		flags[cmp_bit_geu] = ~ltu;
	end

endmodule

// File: rtl/exu_pkg.sv
// Shared definitions for the integer execute unit.
// Holds the word widths, the instruction field positions, the opcode,
// function and shift encodings and the compare-flag bit positions.
// Modules import it inside their bodies and use scoped names in headers.
package exu_pkg;

	// ========================================================================
	// Widths and instruction fields
	// ========================================================================
	localparam int xlen = 64;
	localparam int ilen = 40;
	localparam int op_lsb = 0;
	localparam int op_msb = 6;
	localparam int fn_lsb = 7;
	localparam int fn_msb = 12;
	localparam int shamt_lsb = 13;
	localparam int shamt_msb = 18;
	// Set when the shift amount comes from the instruction rather than b
	localparam int shimm_bit = 19;
	localparam int fill_bit = 20;
	localparam int scale_lsb = 21;
	localparam int scale_msb = 22;
	localparam int csr_lsb = 23;
	localparam int csr_msb = 25;
	localparam int csr_count = 8;

	// Pattern returned for any opcode or function the unit does not know
	localparam logic [xlen-1:0] bad_result = {2{32'hdeadbeef}};

	// Bit positions in the compare-flags word, all other bits read zero
	localparam int cmp_bit_eq = 0;
	localparam int cmp_bit_ne = 1;
	localparam int cmp_bit_lt = 2;
	localparam int cmp_bit_le = 3;
	localparam int cmp_bit_gt = 4;
	localparam int cmp_bit_ge = 5;
	localparam int cmp_bit_ltu = 6;
	localparam int cmp_bit_leu = 7;
	localparam int cmp_bit_gtu = 8;
	localparam int cmp_bit_geu = 9;

	// ========================================================================
	// Encodings
	// ========================================================================
	typedef enum logic [6:0] {
		op_r2 = 7'h02, op_csr = 7'h03, op_addi = 7'h04, op_cmpi = 7'h05,
		op_muli = 7'h06, op_mului = 7'h07, op_divi = 7'h08, op_divui = 7'h09,
		op_andi = 7'h0a, op_ori = 7'h0b, op_eori = 7'h0c, op_slti = 7'h0d,
		op_shift = 7'h0e, op_mov = 7'h0f, op_ld = 7'h10, op_st = 7'h11,
		op_ldx = 7'h12, op_stx = 7'h13, op_pfx = 7'h7f
	} opcode_e;

	// Function codes, only meaningful under op_r2
	typedef enum logic [5:0] {
		fn_add = 6'h00, fn_sub = 6'h01, fn_cmp = 6'h02, fn_mul = 6'h03,
		fn_mulu = 6'h04, fn_mulh = 6'h05, fn_muluh = 6'h06, fn_div = 6'h07,
		fn_mod = 6'h08, fn_divu = 6'h09, fn_modu = 6'h0a, fn_and = 6'h0b,
		fn_or = 6'h0c, fn_eor = 6'h0d, fn_andc = 6'h0e, fn_nand = 6'h0f,
		fn_nor = 6'h10, fn_enor = 6'h11, fn_orc = 6'h12, fn_seq = 6'h13,
		fn_sne = 6'h14, fn_slt = 6'h15, fn_sle = 6'h16, fn_sltu = 6'h17,
		fn_sleu = 6'h18
	} func_e;

	// Shift kinds, carried in the func field under op_shift
	typedef enum logic [5:0] {
		sh_asl = 6'h00, sh_lsr = 6'h01, sh_rol = 6'h02, sh_ror = 6'h03,
		sh_asr = 6'h04
	} shift_e;

endpackage
